//--- rtl/board_cfg.svh
// Game board configuration
// Widths, joystick bit positions, reset countdown length and input polarity

`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// Joystick and colour widths
`define BOARD_JOY_W         16
`define BOARD_GAME_JOY_W    10
`define BOARD_COLOR_W       4

// Set to 1 for games with a third fire button
`define BOARD_THREE_BUTTONS 0

`define BOARD_START1_BIT    (6 + `BOARD_THREE_BUTTONS)
`define BOARD_START2_BIT    (7 + `BOARD_THREE_BUTTONS)
`define BOARD_COIN_BIT      (8 + `BOARD_THREE_BUTTONS)
`define BOARD_PAUSE_BIT     (9 + `BOARD_THREE_BUTTONS)

// Game inputs are active low on most boards
`define BOARD_ACTIVE_LOW    1

// Game reset countdown, all ones is 15 cycles
`define BOARD_GAME_RST_W    4

`define BOARD_GFX_LAYERS    4

`endif

//--- rtl/board_pkg.sv
// Game board types
// Packed structs for keys, joysticks, game inputs, DIP settings and video

`default_nettype none

`include "board_cfg.svh"

package board_pkg;

    typedef struct packed {
        logic [`BOARD_GAME_JOY_W-1:0] joy1;
        logic [`BOARD_GAME_JOY_W-1:0] joy2;
        logic [1:0]                   start;
        logic [1:0]                   coin;
        logic                         reset;   // Soft reset key
        logic                         pause;
        logic                         service;
        logic [`BOARD_GFX_LAYERS-1:0] gfx;
    } key_bus_t;

    // Raw board joysticks
    typedef struct packed {
        logic [`BOARD_JOY_W-1:0] joy1;
        logic [`BOARD_JOY_W-1:0] joy2;
    } joy_pair_t;

    typedef struct packed {
        logic [`BOARD_GAME_JOY_W-1:0] joystick1;
        logic [`BOARD_GAME_JOY_W-1:0] joystick2;
        logic [1:0]                   coin;
        logic [1:0]                   start;
        logic                         service;
    } game_in_t;

    typedef struct packed {
        logic       rot_control;
        logic       flip;
        logic [1:0] fxlevel;
        logic       test;
        logic       dip_pause;   // Low when paused
        logic       enable_fm;
        logic       enable_psg;
        logic       spare;
    } dip_cfg_t;

    typedef struct packed {
        logic [`BOARD_COLOR_W-1:0] r;
        logic [`BOARD_COLOR_W-1:0] g;
        logic [`BOARD_COLOR_W-1:0] b;
        logic                      lhbl;
        logic                      lvbl;
        logic                      hs;
        logic                      vs;
    } game_video_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic       de;
        logic       hs;
        logic       vs;
    } out_video_t;

endpackage

`default_nettype wire

//--- rtl/input_sync.sv
// Input register with rising-edge detection
// Works on any packed payload type

`timescale 1ns/100ps
`default_nettype none

module input_sync #(
    parameter type sig_t = logic [7:0]
) (
    input  wire  clk_sys,
    input  wire  rst,
    input  wire  sig_t d,
    output sig_t q,
    output sig_t rise
);

    // q holds the last sampled value, so d & ~q marks new ones
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            q    <= sig_t'('0);
            rise <= sig_t'('0);
        end else begin
            q    <= d;
            rise <= sig_t'(d & ~q);
        end
    end

    // A pulse can only sit on a bit that is now high
    a_rise_on_high: assert property (
        @(posedge clk_sys) disable iff (rst)
        (rise & ~q) == '0
    );

endmodule

`default_nettype wire

//--- rtl/board_ctrl.sv
// Board control
// Game reset sequencing, soft reset, pause toggle and graphics layer toggles

`timescale 1ns/100ps
`default_nettype none

`include "board_cfg.svh"

module board_ctrl (
    input  wire                          clk_sys,
    input  wire                          rst,
    input  wire                          rst_req,
    input  wire                          downloading,
    input  wire board_pkg::key_bus_t     key_rise,
    input  wire                          joy_pause_rise,
    input  wire                          flip,
    output logic                         game_rst,
    output logic                         game_rst_n,
    output logic                         game_pause,
    output logic [`BOARD_GFX_LAYERS-1:0] gfx_en
);

    localparam int CNT_W = `BOARD_GAME_RST_W;
    localparam logic [CNT_W-1:0] CNT_LAST = {CNT_W{1'b1}};
    localparam logic [CNT_W-1:0] CNT_PREV = CNT_LAST - 1'b1;

    logic             flip_q;
    logic             flip_chg;
    logic             rst_trig;
    logic [CNT_W-1:0] rst_cnt;
    logic             pre_rst_n;

    // A flip change needs a fresh game start
    assign flip_chg = flip != flip_q;
    assign rst_trig = rst | rst_req | downloading | key_rise.reset | flip_chg;

    always_ff @(posedge clk_sys) begin
        if (rst)
            flip_q <= 1'b0;
        else
            flip_q <= flip;
    end

    // Countdown restarts on every trigger
    always_ff @(posedge clk_sys) begin
        if (rst_trig) begin
            rst_cnt  <= '0;
            game_rst <= 1'b1;
        end else if (rst_cnt != CNT_LAST) begin
            rst_cnt  <= rst_cnt + 1'b1;
            game_rst <= rst_cnt != CNT_PREV;   // Drops as the count hits its end
        end else begin
            game_rst <= 1'b0;
        end
    end

    // Two-stage release, dropped together with game_rst
    always_ff @(posedge clk_sys) begin
        if (rst_trig || game_rst) begin
            pre_rst_n  <= 1'b0;
            game_rst_n <= 1'b0;
        end else begin
            pre_rst_n  <= 1'b1;
            game_rst_n <= pre_rst_n;
        end
    end

    // Pause from keyboard or either joystick
    always_ff @(posedge clk_sys) begin
        if (rst)
            game_pause <= 1'b0;
        else if (key_rise.pause || joy_pause_rise)
            game_pause <= ~game_pause;
    end

    always_ff @(posedge clk_sys) begin
        if (rst)
            gfx_en <= '1;   // All layers on
        else
            gfx_en <= gfx_en ^ key_rise.gfx;
    end

    a_rst_holds_game: assert property (
        @(posedge clk_sys) rst |=> game_rst
    );

    // Release only once the countdown is over
    a_rst_n_exclusive: assert property (
        @(posedge clk_sys) disable iff (rst)
        !(game_rst && game_rst_n)
    );

endmodule

`default_nettype wire

//--- rtl/joy_mapper.sv
// Joystick mapper
// Merges board joysticks with keys, applies rotation and input polarity

`timescale 1ns/100ps
`default_nettype none

`include "board_cfg.svh"

module joy_mapper (
    input  wire                       clk_sys,
    input  wire                       rst,
    input  wire board_pkg::joy_pair_t joy,
    input  wire board_pkg::key_bus_t  keys,
    input  wire                       rot_control,
    output board_pkg::game_in_t       game_in
);

    localparam int JW   = `BOARD_GAME_JOY_W;
    localparam int IN_W = $bits(board_pkg::game_in_t);
    localparam logic INV = 1'(`BOARD_ACTIVE_LOW);

    board_pkg::game_in_t mapped;

    // Rotated screen swaps the direction bits, buttons stay put
    function automatic logic [JW-1:0] rotate_dirs(
        input logic [JW-1:0] j,
        input logic          rot
    );
        if (rot)
            return {j[JW-1:4], j[0], j[1], j[3], j[2]};
        else
            return j;
    endfunction

    always_comb begin
        mapped.joystick1 = rotate_dirs(joy.joy1[JW-1:0] | keys.joy1, rot_control);
        mapped.joystick2 = rotate_dirs(joy.joy2[JW-1:0] | keys.joy2, rot_control);
        mapped.coin      = {joy.joy2[`BOARD_COIN_BIT], joy.joy1[`BOARD_COIN_BIT]} | keys.coin;
        // Either player's joystick can start either player
        mapped.start     = {joy.joy1[`BOARD_START2_BIT] | joy.joy2[`BOARD_START2_BIT],
                            joy.joy1[`BOARD_START1_BIT] | joy.joy2[`BOARD_START1_BIT]}
                           | keys.start;
        mapped.service   = keys.service;
    end

    always_ff @(posedge clk_sys) begin
        if (rst)
            game_in <= board_pkg::game_in_t'({IN_W{INV}});   // Everything released
        else
            game_in <= board_pkg::game_in_t'(mapped ^ {IN_W{INV}});
    end

endmodule

`default_nettype wire

//--- rtl/dip_decode.sv
// DIP decoder
// Turns the OSD status word into registered DIP settings

`timescale 1ns/100ps
`default_nettype none

module dip_decode (
    input  wire                 clk_sys,
    input  wire                 rst,
    input  wire  [31:0]         status,
    input  wire                 game_pause,
    output board_pkg::dip_cfg_t dip
);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dip            <= '0;
            dip.dip_pause  <= 1'b1;   // Running
            dip.enable_fm  <= 1'b1;
            dip.enable_psg <= 1'b1;
        end else begin
            dip.rot_control <= status[2];
            dip.flip        <= status[3];
            dip.fxlevel     <= status[5:4];
            dip.test        <= status[6];
            // OSD pause or the game pause toggle both stop the game
            dip.dip_pause   <= ~(status[7] | game_pause);
            dip.enable_fm   <= ~status[8];   // Sound chips on by default
            dip.enable_psg  <= ~status[9];
            dip.spare       <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/video_expand.sv
// Video widening
// Expands game colour to 8 bits per channel and forms data enable on pxl_cen

`timescale 1ns/100ps
`default_nettype none

`include "board_cfg.svh"

module video_expand (
    input  wire                         clk_sys,
    input  wire                         rst,
    input  wire                         pxl_cen,
    input  wire board_pkg::game_video_t vin,
    output board_pkg::out_video_t       vout
);

    localparam int CW  = `BOARD_COLOR_W;
    localparam int REP = (8 + CW - 1) / CW;   // Copies needed to fill 8 bits

    logic [7:0] r_q;
    logic [7:0] g_q;
    logic [7:0] b_q;
    logic       de_q;
    logic       hs_q;
    logic       vs_q;

    // Repeat the channel so full scale maps to 8'hff
    function automatic logic [7:0] widen(input logic [CW-1:0] c);
        logic [REP*CW-1:0] rep;
        rep = {REP{c}};
        return rep[REP*CW-1 -: 8];
    endfunction

    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            r_q <= widen(vin.r);
            g_q <= widen(vin.g);
            b_q <= widen(vin.b);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            de_q <= 1'b0;
            hs_q <= 1'b0;
            vs_q <= 1'b0;
        end else if (pxl_cen) begin
            de_q <= vin.lhbl & vin.lvbl;   // Both blanks inactive
            hs_q <= vin.hs;
            vs_q <= vin.vs;
        end
    end

    assign vout = '{r: r_q, g: g_q, b: b_q, de: de_q, hs: hs_q, vs: vs_q};

    // A blanked pixel must never show as active
    a_de_blank: assert property (
        @(posedge clk_sys) disable iff (rst)
        pxl_cen && !(vin.lhbl && vin.lvbl) |=> !vout.de
    );

endmodule

`default_nettype wire

//--- rtl/game_board.sv
// Arcade game board core
// Input sync, reset sequencing, joystick mapping, DIP decoding and video widening

`timescale 1ns/100ps
`default_nettype none

`include "board_cfg.svh"

module game_board (
    input  wire                          clk_sys,
    input  wire                          rst,
    input  wire                          rst_req,
    input  wire                          downloading,
    input  wire board_pkg::joy_pair_t    board_joy,
    input  wire board_pkg::key_bus_t     key_in,
    input  wire  [31:0]                  status,
    input  wire                          pxl_cen,
    input  wire board_pkg::game_video_t  game_video,
    output logic                         game_rst,
    output logic                         game_rst_n,
    output board_pkg::game_in_t          game_in,
    output logic                         game_pause,
    output logic [`BOARD_GFX_LAYERS-1:0] gfx_en,
    output board_pkg::dip_cfg_t          dip,
    output board_pkg::out_video_t        out_video
);

    board_pkg::joy_pair_t joy_q;
    board_pkg::joy_pair_t joy_rise;
    board_pkg::key_bus_t  key_q;
    board_pkg::key_bus_t  key_rise;

    input_sync #(.sig_t(board_pkg::joy_pair_t)) u_joy_sync (
        .clk_sys (clk_sys),
        .rst     (rst),
        .d       (board_joy),
        .q       (joy_q),
        .rise    (joy_rise)
    );

    input_sync #(.sig_t(board_pkg::key_bus_t)) u_key_sync (
        .clk_sys (clk_sys),
        .rst     (rst),
        .d       (key_in),
        .q       (key_q),
        .rise    (key_rise)
    );

    board_ctrl u_ctrl (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .rst_req        (rst_req),
        .downloading    (downloading),
        .key_rise       (key_rise),
        // Pause button on either joystick
        .joy_pause_rise (joy_rise.joy1[`BOARD_PAUSE_BIT] | joy_rise.joy2[`BOARD_PAUSE_BIT]),
        .flip           (dip.flip),
        .game_rst       (game_rst),
        .game_rst_n     (game_rst_n),
        .game_pause     (game_pause),
        .gfx_en         (gfx_en)
    );

    joy_mapper u_joy_map (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .joy         (joy_q),
        .keys        (key_q),
        .rot_control (dip.rot_control),
        .game_in     (game_in)
    );

    dip_decode u_dip (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .status     (status),
        .game_pause (game_pause),
        .dip        (dip)
    );

    video_expand u_video (
        .clk_sys (clk_sys),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .vin     (game_video),
        .vout    (out_video)
    );

endmodule

`default_nettype wire

//--- tests/game_board_tb.sv
// Game board testbench
// Random and directed stimulus, checked every cycle against reference models

`timescale 1ns/100ps
`default_nettype none

`include "board_cfg.svh"

module game_board_tb;

    localparam int HALF_PERIOD = 20;
    localparam int JW          = `BOARD_GAME_JOY_W;
    localparam int CW          = `BOARD_COLOR_W;
    localparam int RST_CYCLES  = (1 << `BOARD_GAME_RST_W) - 1;
    localparam int TEST_CYCLES = 30 + 205 + 35 + 4 * 25 + 80 + 105;
    localparam int TIMEOUT_NS  = (TEST_CYCLES + 200) * 2 * HALF_PERIOD;

    // Everything driven into the DUT
    typedef struct packed {
        logic                   rst;
        logic                   rst_req;
        logic                   downloading;
        board_pkg::joy_pair_t   joy;
        board_pkg::key_bus_t    key;
        logic [31:0]            status;
        logic                   pxl_cen;
        board_pkg::game_video_t video;
    } stim_t;

    logic                         clk_sys = 1'b0;
    stim_t                        drv;
    stim_t                        h0;
    stim_t                        h1 = '0;   // Inputs of the two previous edges
    stim_t                        h2 = '0;
    logic                         game_rst;
    logic                         game_rst_n;
    logic                         game_pause;
    logic [`BOARD_GFX_LAYERS-1:0] gfx_en;
    board_pkg::game_in_t          game_in;
    board_pkg::dip_cfg_t          dip;
    board_pkg::out_video_t        out_video;

    int                           since = RST_CYCLES;   // Cycles since last reset trigger
    logic                         gr1 = 1'b1;
    logic                         gr2 = 1'b1;
    logic                         pause_m = 1'b0;
    logic [`BOARD_GFX_LAYERS-1:0] gfx_m = '1;
    board_pkg::out_video_t        video_m = '0;
    logic                         video_valid = 1'b0;   // Set once a pixel was latched
    logic [31:0]                  rng = 32'hfaf9_29a0;
    string                        test_name = "reset";
    int                           errors = 0;
    int                           checks = 0;

    always #HALF_PERIOD clk_sys = ~clk_sys;

    game_board u_game_board (
        .clk_sys     (clk_sys),
        .rst         (drv.rst),
        .rst_req     (drv.rst_req),
        .downloading (drv.downloading),
        .board_joy   (drv.joy),
        .key_in      (drv.key),
        .status      (drv.status),
        .pxl_cen     (drv.pxl_cen),
        .game_video  (drv.video),
        .game_rst    (game_rst),
        .game_rst_n  (game_rst_n),
        .game_in     (game_in),
        .game_pause  (game_pause),
        .gfx_en      (gfx_en),
        .dip         (dip),
        .out_video   (out_video)
    );

    // Advances the random state and returns it
    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [JW-1:0] swap_dirs(input logic [JW-1:0] j, input logic rot);
        logic [JW-1:0] o;
        o = j;
        if (rot) begin
            o[3] = j[0];
            o[2] = j[1];
            o[1] = j[3];
            o[0] = j[2];
        end
        return o;
    endfunction

    function automatic board_pkg::game_in_t map_inputs(
        input board_pkg::joy_pair_t j,
        input board_pkg::key_bus_t  k,
        input logic                 rot
    );
        board_pkg::game_in_t g;
        g.joystick1 = swap_dirs(j.joy1[JW-1:0] | k.joy1, rot);
        g.joystick2 = swap_dirs(j.joy2[JW-1:0] | k.joy2, rot);
        g.coin[0]   = j.joy1[`BOARD_COIN_BIT] | k.coin[0];
        g.coin[1]   = j.joy2[`BOARD_COIN_BIT] | k.coin[1];
        g.start[0]  = j.joy1[`BOARD_START1_BIT] | j.joy2[`BOARD_START1_BIT] | k.start[0];
        g.start[1]  = j.joy1[`BOARD_START2_BIT] | j.joy2[`BOARD_START2_BIT] | k.start[1];
        g.service   = k.service;
        if (`BOARD_ACTIVE_LOW)
            g = ~g;
        return g;
    endfunction

    function automatic board_pkg::dip_cfg_t decode_status(input logic [31:0] s,
                                                          input logic paused);
        board_pkg::dip_cfg_t d;
        d.rot_control = s[2];
        d.flip        = s[3];
        d.fxlevel     = s[5:4];
        d.test        = s[6];
        d.dip_pause   = !(s[7] || paused);
        d.enable_fm   = !s[8];
        d.enable_psg  = !s[9];
        d.spare       = 1'b0;
        return d;
    endfunction

    // Each channel repeated from its top bit until 8 bits are filled
    function automatic board_pkg::out_video_t widen_video(input board_pkg::game_video_t v);
        board_pkg::out_video_t o;
        for (int i = 0; i < 8; i++) begin
            o.r[7 - i] = v.r[CW - 1 - (i % CW)];
            o.g[7 - i] = v.g[CW - 1 - (i % CW)];
            o.b[7 - i] = v.b[CW - 1 - (i % CW)];
        end
        o.de = v.lhbl & v.lvbl;
        o.hs = v.hs;
        o.vs = v.vs;
        return o;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_sys);
        #2;
    endtask

    // Model state steps once per edge
    always begin : compare_outputs
        logic gr;
        logic trig;
        logic pause_rise;
        @(posedge clk_sys);
        h0 = drv;   // What this edge samples
        #1;
        trig = h0.rst | h0.rst_req | h0.downloading | (h1.key.reset & ~h2.key.reset)
               | (h1.status[3] ^ h2.status[3]);   // Key and flip seen one cycle late
        if (trig)
            since = 0;
        else if (since < RST_CYCLES)
            since++;
        gr = since < RST_CYCLES;
        pause_rise = (h1.key.pause & ~h2.key.pause)
                     | (h1.joy.joy1[`BOARD_PAUSE_BIT] & ~h2.joy.joy1[`BOARD_PAUSE_BIT])
                     | (h1.joy.joy2[`BOARD_PAUSE_BIT] & ~h2.joy.joy2[`BOARD_PAUSE_BIT]);
        compare_value("game_rst", 32'(gr), 32'(game_rst));
        compare_value("game_rst_n", 32'(!(gr | gr1 | gr2)), 32'(game_rst_n));
        compare_value("dip",
                      32'(decode_status(h0.rst ? 32'd0 : h0.status, pause_m & !h0.rst)),
                      32'(dip));
        pause_m = !h0.rst && (pause_m ^ pause_rise);
        gfx_m   = h0.rst ? '1 : gfx_m ^ (h1.key.gfx & ~h2.key.gfx);
        compare_value("game_pause", 32'(pause_m), 32'(game_pause));
        compare_value("gfx_en", 32'(gfx_m), 32'(gfx_en));
        compare_value("game_in", 32'(h0.rst ? map_inputs('0, '0, 1'b0)
                                            : map_inputs(h1.joy, h1.key, h1.status[2])),
                      32'(game_in));
        if (h0.rst) begin
            video_m.de = 1'b0;
            video_m.hs = 1'b0;
            video_m.vs = 1'b0;
        end else if (h0.pxl_cen) begin
            video_m     = widen_video(h0.video);
            video_valid = 1'b1;
        end
        compare_value("de/hs/vs", 32'({video_m.de, video_m.hs, video_m.vs}),
                      32'({out_video.de, out_video.hs, out_video.vs}));
        if (video_valid)
            compare_value("rgb", 32'({video_m.r, video_m.g, video_m.b}),
                          32'({out_video.r, out_video.g, out_video.b}));
        h2  = h1;
        h1  = h0;
        gr2 = gr1;
        gr1 = gr;
    end

    initial begin : stimulus
        logic [31:0] r;
        drv     = '0;
        drv.rst = 1'b1;
        repeat (10) next_cycle();
        drv.rst = 1'b0;
        repeat (20) next_cycle();   // Countdown and two-stage release

        test_name = "joystick";
        for (int i = 0; i < 200; i++) begin
            r             = xorshift();
            drv.key       = r[30:0];
            drv.key.reset = 1'b0;   // Soft reset tested on its own
            drv.joy       = xorshift();
            drv.status[2] = (i >= 100);   // Rotation on for the second half
            next_cycle();
        end
        drv.joy    = '0;
        drv.key    = '0;
        drv.status = '0;
        repeat (5) next_cycle();

        test_name     = "toggles";
        drv.key.pause = 1'b1;
        repeat (4) next_cycle();   // Held key toggles once
        drv.key.pause = 1'b0;
        repeat (3) next_cycle();
        drv.joy.joy2[`BOARD_PAUSE_BIT] = 1'b1;
        repeat (3) next_cycle();
        drv.joy = '0;
        repeat (3) next_cycle();
        for (int g = 0; g < `BOARD_GFX_LAYERS; g++) begin
            drv.key.gfx[g] = 1'b1;
            repeat (3) next_cycle();
            drv.key.gfx[g] = 1'b0;
            repeat (2) next_cycle();
        end

        test_name     = "soft reset";
        drv.key.reset = 1'b1;
        next_cycle();
        drv.key.reset = 1'b0;
        repeat (22) next_cycle();
        test_name     = "flip";
        drv.status[3] = 1'b1;
        repeat (22) next_cycle();
        test_name   = "rst_req";
        drv.rst_req = 1'b1;
        repeat (3) next_cycle();
        drv.rst_req = 1'b0;
        repeat (20) next_cycle();
        test_name       = "downloading";
        drv.downloading = 1'b1;
        repeat (3) next_cycle();
        drv.downloading = 1'b0;
        repeat (20) next_cycle();

        test_name = "status";
        for (int i = 0; i < 60; i++) begin
            drv.status = xorshift();
            next_cycle();
        end
        drv.status = '0;
        repeat (20) next_cycle();

        test_name = "video";
        for (int i = 0; i < 100; i++) begin
            r           = xorshift();
            drv.video   = r[15:0];
            drv.pxl_cen = (i % 4 == 0);
            next_cycle();
        end
        drv.pxl_cen = 1'b0;
        repeat (3) next_cycle();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout, run still going after %0d ns, errors: %0d", TIMEOUT_NS, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- game_board.f
+incdir+rtl
rtl/board_pkg.sv
rtl/input_sync.sv
rtl/board_ctrl.sv
rtl/joy_mapper.sv
rtl/dip_decode.sv
rtl/video_expand.sv
rtl/game_board.sv
tests/game_board_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the game_board testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module game_board_tb -f game_board.f -o game_board_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/game_board_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "Simulation reported failure"
exit 1
